// File: paint_consts.svh
// ====================
// frame geometry, sync timing, cursor size and colours of the paint display
// include wherever a module needs the raw numbers
// ====================
`ifndef PAINT_CONSTS_SVH
`define PAINT_CONSTS_SVH

// visible area in pixels and lines
`define H_DISPLAY 32
`define V_DISPLAY 24

// horizontal blanking, in pixels
`define H_FRONT 4
`define H_SYNC 6
`define H_BACK 6

// vertical blanking, in lines
`define V_FRONT 2
`define V_SYNC 2
`define V_BACK 4

// cursor box reaches half the size on each side, ends inclusive
`define CURSOR_SIZE 4

// green and blue of the canvas, full rgb of the cursor box
`define CANVAS_GB 2'b11
`define CURSOR_RGB 3'b010

`endif

// File: vga_scan_pkg.sv
// ====================
// raster position and scan beat types shared by the display pipeline
// ====================
package vga_scan_pkg;

	// wide enough for the full line total (48)
	typedef logic [5:0] hpos_t;

	// wide enough for the full frame total (32)
	typedef logic [4:0] vpos_t;

	// one pixel slot of the raster walk
	// display_on marks the visible area
	// syncs are high active
	typedef struct packed {
		hpos_t hpos;
		vpos_t vpos;
		logic display_on;
		logic hsync;
		logic vsync;
	} scan_beat_t;

endpackage

// File: paint_pkg.sv
// ====================
// key codes, colours and wishbone bus types of the paint subsystem
// ====================
package paint_pkg;

	// one bit per colour channel, red on top
	typedef struct packed {
		logic r;
		logic g;
		logic b;
	} rgb_t;

	// cursor keys, sampled on move ticks
	// code 7 has no meaning and is ignored
	typedef enum logic [2:0] {
		KEY_NONE = 3'd0,
		KEY_LEFT = 3'd1,
		KEY_RIGHT = 3'd2,
		KEY_UP = 3'd3,
		KEY_DOWN = 3'd4,
		KEY_PAINT = 3'd5,
		KEY_ERASE = 3'd6
	} key_code_t;

	// pixel index, y * H_DISPLAY + x
	typedef logic [9:0] wb_adr_t;

	// only bit 0 is stored
	typedef logic [7:0] wb_dat_t;

endpackage

// File: scan_if.sv
// ====================
// one scan beat passed from one pipeline stage to the next
// ====================
`timescale 1ns/100ps

interface scan_if import vga_scan_pkg::*; ();

	// position, visible flag and syncs of the current slot
	scan_beat_t beat;

	// the stage that produces the beat
	modport src (
		output beat
	);

	// the stage that consumes it
	// no back-pressure, the beat is taken every clock
	modport dst (
		input beat
	);

endinterface

// File: cursor_if.sv
// ====================
// cursor position and paint requests from the cursor controller
// ====================
`timescale 1ns/100ps

interface cursor_if import vga_scan_pkg::*; ();

	hpos_t x;
	vpos_t y;
	// one cycle pulse, write paint_bit under the cursor
	logic paint_req;
	logic paint_bit;

	modport ctrl (output x, output y, output paint_req, output paint_bit);

	// buffer needs position and the request
	modport fb (input x, input y, input paint_req, input paint_bit);

	// overlay draws the box only
	modport ovl (input x, input y);

endinterface

// File: scan_timing.sv
// ====================
// stage 0, raster counters giving position, display enable and syncs
// ====================
`timescale 1ns/100ps
`include "paint_consts.svh"

module scan_timing import vga_scan_pkg::*; (
	input logic clk,
	input logic reset,
	scan_if.src out_scan
);

	// line and frame totals
	localparam int H_TOTAL = `H_DISPLAY + `H_FRONT + `H_SYNC + `H_BACK;
	localparam int V_TOTAL = `V_DISPLAY + `V_FRONT + `V_SYNC + `V_BACK;

	// sync windows, start inclusive, end exclusive
	localparam int HS_START = `H_DISPLAY + `H_FRONT;
	localparam int HS_END = HS_START + `H_SYNC;
	localparam int VS_START = `V_DISPLAY + `V_FRONT;
	localparam int VS_END = VS_START + `V_SYNC;

	hpos_t h_cnt;
	vpos_t v_cnt;
	logic line_end;

	assign line_end = (h_cnt == hpos_t'(H_TOTAL - 1));

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else begin
			if (line_end) begin
				h_cnt <= '0;
				// next line, wrap at frame end
				if (v_cnt == vpos_t'(V_TOTAL - 1))
					v_cnt <= '0;
				else
					v_cnt <= v_cnt + 1'b1;
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	// beat straight from the counters
	// downstream stages add the register delay
	always_comb begin
		out_scan.beat.hpos = h_cnt;
		out_scan.beat.vpos = v_cnt;
		out_scan.beat.display_on = (h_cnt < `H_DISPLAY) && (v_cnt < `V_DISPLAY);
		out_scan.beat.hsync = (h_cnt >= HS_START) && (h_cnt < HS_END);
		out_scan.beat.vsync = (v_cnt >= VS_START) && (v_cnt < VS_END);
	end

	// sync pulse must sit in blanking
	a_hsync_blank: assert property (
		@(posedge clk) disable iff (reset)
		out_scan.beat.hsync |-> !out_scan.beat.display_on
	);

endmodule

// File: cursor_ctrl.sv
// ====================
// cursor position register, clamped moves and paint or erase requests
// ====================
`timescale 1ns/100ps
`include "paint_consts.svh"

module cursor_ctrl import vga_scan_pkg::*, paint_pkg::*; (
	input logic clk,
	input logic reset,
	input key_code_t key,
	input logic move_tick,
	cursor_if.ctrl cur
);

	// last legal column and row
	localparam hpos_t X_MAX = hpos_t'(`H_DISPLAY - 1);
	localparam vpos_t Y_MAX = vpos_t'(`V_DISPLAY - 1);

	// start in the middle of the screen
	localparam hpos_t X_HOME = hpos_t'(`H_DISPLAY / 2);
	localparam vpos_t Y_HOME = vpos_t'(`V_DISPLAY / 2);

	logic paint_key;

	assign paint_key = (key == KEY_PAINT) || (key == KEY_ERASE);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cur.x <= X_HOME;
			cur.y <= Y_HOME;
			cur.paint_req <= 1'b0;
		end else begin
			// request lasts one cycle only
			cur.paint_req <= move_tick && paint_key;
			if (move_tick) begin
				case (key)
					// each step saturates at the edge
					KEY_LEFT: if (cur.x != '0) cur.x <= cur.x - 1'b1;
					KEY_RIGHT: if (cur.x != X_MAX) cur.x <= cur.x + 1'b1;
					// y grows downwards
					KEY_UP: if (cur.y != '0) cur.y <= cur.y - 1'b1;
					KEY_DOWN: if (cur.y != Y_MAX) cur.y <= cur.y + 1'b1;
					default: ;
				endcase
			end
		end
	end

	// bit that goes with the request
	// paint sets and erase clears
	always_ff @(posedge clk) begin
		if (move_tick && paint_key)
			cur.paint_bit <= (key == KEY_PAINT);
	end

	// buffer index relies on the cursor staying visible
	a_cursor_inside: assert property (
		@(posedge clk) disable iff (reset)
		(cur.x < `H_DISPLAY) && (cur.y < `V_DISPLAY)
	);

endmodule

// File: frame_buffer.sv
// ====================
// stage 1, one bit per pixel memory with scan read, paint write
// and a wishbone classic slave port for the host
// ====================
`timescale 1ns/100ps
`include "paint_consts.svh"

module frame_buffer import vga_scan_pkg::*, paint_pkg::*; (
	input logic clk,
	input logic reset,
	scan_if.dst in_scan,
	scan_if.src out_scan,
	cursor_if.fb cur,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input wb_adr_t wb_adr,
	input wb_dat_t wb_dat_w,
	output wb_dat_t wb_dat_r,
	output logic wb_ack,
	output logic pix_bit
);

	localparam int DEPTH = `H_DISPLAY * `V_DISPLAY;

	// 768 bits, cleared by reset so the canvas starts blank
	logic [DEPTH-1:0] mem;

	wb_adr_t scan_idx;
	wb_adr_t paint_idx;
	logic wb_req;
	logic port_busy;
	logic adr_ok;
	logic rd_bit;

	function automatic wb_adr_t pix_index(input hpos_t x, input vpos_t y);
		pix_index = wb_adr_t'(y * `H_DISPLAY + x);
	endfunction

	assign scan_idx = pix_index(in_scan.beat.hpos, in_scan.beat.vpos);
	assign paint_idx = pix_index(cur.x, cur.y);

	// open request, not yet acked
	assign wb_req = wb_cyc && wb_stb && !wb_ack;
	// paint owns the write port, bus write waits a cycle
	assign port_busy = cur.paint_req && wb_we;
	// addresses past the last pixel read 0, writes dropped
	assign adr_ok = (wb_adr < DEPTH);
	assign rd_bit = adr_ok ? mem[wb_adr] : 1'b0;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			mem <= '0;
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= wb_req && !port_busy;
			// single write port, paint first
			if (cur.paint_req)
				mem[paint_idx] <= cur.paint_bit;
			else if (wb_req && wb_we && adr_ok)
				mem[wb_adr] <= wb_dat_w[0];
		end
	end

	// read data held for the ack cycle
	always_ff @(posedge clk) begin
		if (wb_req && !wb_we)
			wb_dat_r <= {{($bits(wb_dat_t) - 1){1'b0}}, rd_bit};
	end

	// scan read, one clock, beat delayed to match
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			out_scan.beat <= '0;
			pix_bit <= 1'b0;
		end else begin
			out_scan.beat <= in_scan.beat;
			pix_bit <= in_scan.beat.display_on ? mem[scan_idx] : 1'b0;
		end
	end

	a_ack_needs_req: assert property (
		@(posedge clk) disable iff (reset)
		$rose(wb_ack) |-> $past(wb_cyc && wb_stb)
	);

	a_ack_pulse: assert property (
		@(posedge clk) disable iff (reset)
		wb_ack |=> !wb_ack
	);

endmodule

// File: sprite_overlay.sv
// ====================
// stage 2, draws the cursor box over buffer red and the green/blue canvas
// ====================
`timescale 1ns/100ps
`include "paint_consts.svh"

module sprite_overlay import vga_scan_pkg::*, paint_pkg::*; (
	input logic clk,
	input logic reset,
	scan_if.dst in_scan,
	input logic pix_bit,
	cursor_if.ovl cur,
	output rgb_t rgb,
	output logic de,
	output logic hsync,
	output logic vsync
);

	localparam int HALF = `CURSOR_SIZE / 2;

	// signed copies, one spare bit each way
	// box edges can go below 0 near the border
	logic signed [7:0] px;
	logic signed [7:0] py;
	logic signed [7:0] cx;
	logic signed [7:0] cy;
	logic in_box;

	assign px = $signed({2'b00, in_scan.beat.hpos});
	assign py = $signed({3'b000, in_scan.beat.vpos});
	assign cx = $signed({2'b00, cur.x});
	assign cy = $signed({3'b000, cur.y});

	// inclusive on both ends
	assign in_box = (px >= cx - HALF) && (px <= cx + HALF) &&
		(py >= cy - HALF) && (py <= cy + HALF);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rgb <= '0;
			de <= 1'b0;
			hsync <= 1'b0;
			vsync <= 1'b0;
		end else begin
			de <= in_scan.beat.display_on;
			hsync <= in_scan.beat.hsync;
			vsync <= in_scan.beat.vsync;
			if (!in_scan.beat.display_on)
				rgb <= '0;
			else if (in_box)
				// cursor colour is fixed, buffer ignored
				rgb <= `CURSOR_RGB;
			else
				rgb <= {pix_bit, `CANVAS_GB};
		end
	end

endmodule

// File: paint_top.sv
// ====================
// paint subsystem top, scan -> buffer read -> overlay with cursor and host bus
// ====================
`timescale 1ns/100ps

module paint_top import vga_scan_pkg::*, paint_pkg::*; (
	input logic clk,
	input logic reset,
	input key_code_t key,
	input logic move_tick,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input wb_adr_t wb_adr,
	input wb_dat_t wb_dat_w,
	output wb_dat_t wb_dat_r,
	output logic wb_ack,
	output rgb_t rgb,
	output logic de,
	output logic hsync,
	output logic vsync,
	output hpos_t cursor_x,
	output vpos_t cursor_y
);

	// stage 0 to stage 1, then stage 1 to stage 2
	scan_if scan0 ();
	scan_if scan1 ();
	cursor_if cur ();

	logic pix_bit;

	scan_timing u_scan (
		.clk(clk),
		.reset(reset),
		.out_scan(scan0)
	);

	cursor_ctrl u_cursor (
		.clk(clk),
		.reset(reset),
		.key(key),
		.move_tick(move_tick),
		.cur(cur)
	);

	frame_buffer u_fb (
		.clk(clk),
		.reset(reset),
		.in_scan(scan0),
		.out_scan(scan1),
		.cur(cur),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.pix_bit(pix_bit)
	);

	// outputs two clocks behind the stage 0 beat
	sprite_overlay u_ovl (
		.clk(clk),
		.reset(reset),
		.in_scan(scan1),
		.pix_bit(pix_bit),
		.cur(cur),
		.rgb(rgb),
		.de(de),
		.hsync(hsync),
		.vsync(vsync)
	);

	assign cursor_x = cur.x;
	assign cursor_y = cur.y;

endmodule

// File: tb_paint_top.sv
// ====================
// directed testbench for paint_top
// checks bus, cursor and whole frames against a small reference model
// ====================
`timescale 1ns/100ps
`include "paint_consts.svh"

module tb_paint_top import vga_scan_pkg::*, paint_pkg::*; ();

	localparam int FRAME_CLKS = (`H_DISPLAY + `H_FRONT + `H_SYNC + `H_BACK) *
		(`V_DISPLAY + `V_FRONT + `V_SYNC + `V_BACK);
	localparam int NUM_TESTS = 6;
	localparam int TIMEOUT_NS = 6 * FRAME_CLKS * NUM_TESTS * 20;
	localparam int ACK_LIMIT = 8;
	localparam int HALF = `CURSOR_SIZE / 2;

	logic clk = 1'b0;
	logic reset;
	key_code_t key;
	logic move_tick;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	wb_adr_t wb_adr;
	wb_dat_t wb_dat_w;
	wb_dat_t wb_dat_r;
	logic wb_ack;
	rgb_t rgb;
	logic de;
	logic hsync;
	logic vsync;
	hpos_t cursor_x;
	vpos_t cursor_y;

	// reference model of the pixel bits and the cursor
	bit model_px [`V_DISPLAY][`H_DISPLAY];
	int mx;
	int my;
	logic [31:0] lcg_state = 32'hc688;

	paint_top dut (.*);

	always #10 clk = ~clk;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// colour the display should show at (x, y)
	function automatic rgb_t expected_rgb(input int x, input int y);
		if (x >= mx - HALF && x <= mx + HALF && y >= my - HALF && y <= my + HALF)
			return rgb_t'(`CURSOR_RGB);
		return rgb_t'({model_px[y][x], `CANVAS_GB});
	endfunction

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Some tests failed");
		$fatal(1, "stopping at first error");
	endtask

	// one clock step
	// inputs change and outputs are read 2 ns after the edge
	task automatic step();
		@(posedge clk);
		#2;
	endtask

	task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
		if (exp !== act)
			fail_now($sformatf("FAIL %s rgb expected %b actual %b", name, exp, act));
	endtask

	task automatic check_dat(input string name, input wb_dat_t exp, input wb_dat_t act);
		if (exp !== act)
			fail_now($sformatf("FAIL %s data expected %h actual %h", name, exp, act));
	endtask

	task automatic check_pos(input string name, input hpos_t ex, input vpos_t ey,
		input hpos_t ax, input vpos_t ay);
		if (ex !== ax || ey !== ay)
			fail_now($sformatf("FAIL %s cursor expected (%0d,%0d) actual (%0d,%0d)",
				name, ex, ey, ax, ay));
	endtask

	// key with one move tick and an idle cycle so a paint write lands
	task automatic press(input key_code_t k);
		key = k;
		move_tick = 1'b1;
		case (k)
			KEY_LEFT: if (mx > 0) mx--;
			KEY_RIGHT: if (mx < `H_DISPLAY - 1) mx++;
			KEY_UP: if (my > 0) my--;
			KEY_DOWN: if (my < `V_DISPLAY - 1) my++;
			KEY_PAINT: model_px[my][mx] = 1'b1;
			KEY_ERASE: model_px[my][mx] = 1'b0;
			default: ;
		endcase
		step();
		move_tick = 1'b0;
		key = KEY_NONE;
		step();
	endtask

	// hold the request until ack and drop it one cycle later
	task automatic wb_cycle(input string name, input logic we, input wb_adr_t adr,
		input wb_dat_t dat, input int exp_lat, output wb_dat_t rd);
		int lat;
		lat = 0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = dat;
		do begin
			step();
			lat++;
			if (lat > ACK_LIMIT)
				fail_now($sformatf("%s no wishbone ack within %0d cycles", name, ACK_LIMIT));
		end while (!wb_ack);
		rd = wb_dat_r;
		if (lat != exp_lat)
			fail_now($sformatf("FAIL %s ack latency expected %0d actual %0d",
				name, exp_lat, lat));
		step();
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		if (wb_ack)
			fail_now($sformatf("%s wishbone ack stayed high for two cycles", name));
	endtask

	task automatic wb_write(input string name, input wb_adr_t adr, input wb_dat_t dat,
		input int exp_lat);
		wb_dat_t rd;
		wb_cycle(name, 1'b1, adr, dat, exp_lat, rd);
		model_px[adr / `H_DISPLAY][adr % `H_DISPLAY] = dat[0];
	endtask

	task automatic wb_read_check(input string name, input wb_adr_t adr);
		wb_dat_t rd;
		wb_cycle(name, 1'b0, adr, '0, 1, rd);
		check_dat(name, wb_dat_t'(model_px[adr / `H_DISPLAY][adr % `H_DISPLAY]), rd);
	endtask

	// line 0 is the first de line after vsync falls
	// blanking before each line shows black and carries an hsync pulse
	task automatic capture_frame(input string name);
		logic seen_hs;
		while (!vsync)
			step();
		while (vsync)
			step();
		for (int y = 0; y < `V_DISPLAY; y++) begin
			seen_hs = 1'b0;
			while (!de) begin
				if (hsync)
					seen_hs = 1'b1;
				check_rgb($sformatf("%s blank before line %0d", name, y), '0, rgb);
				step();
			end
			if (!seen_hs)
				fail_now($sformatf("%s no hsync pulse before line %0d", name, y));
			for (int x = 0; x < `H_DISPLAY; x++) begin
				if (!de)
					fail_now($sformatf("%s de dropped inside line %0d", name, y));
				if (hsync || vsync)
					fail_now($sformatf("%s sync high while de is high", name));
				check_rgb($sformatf("%s (%0d,%0d)", name, x, y), expected_rgb(x, y), rgb);
				step();
			end
		end
	endtask

	task automatic test_reset();
		repeat (8) step();
		check_rgb("reset", '0, rgb);
		if (de || hsync || vsync || wb_ack)
			fail_now("reset outputs not low while reset is held");
		reset = 1'b0;
		step();
		check_pos("reset", hpos_t'(mx), vpos_t'(my), cursor_x, cursor_y);
		capture_frame("reset frame");
	endtask

	task automatic test_wb_random();
		logic [31:0] r;
		for (int i = 0; i < 8; i++) begin
			r = lcg_next();
			wb_write("wb random", wb_adr_t'((r >> 12) % 768), wb_dat_t'(r >> 4), 1);
			wb_read_check("wb readback", wb_adr_t'((r >> 12) % 768));
		end
		// mostly unwritten places where the model holds 0
		for (int i = 0; i < 8; i++) begin
			r = lcg_next();
			wb_read_check("wb unwritten", wb_adr_t'((r >> 12) % 768));
		end
	endtask

	task automatic test_wb_frame();
		logic [31:0] r;
		for (int i = 0; i < 6; i++) begin
			r = lcg_next();
			wb_write("wb frame", wb_adr_t'((r >> 12) % 768), 8'h01, 1);
		end
		// one pixel inside the box stays hidden by the cursor
		wb_write("wb frame", wb_adr_t'(my * `H_DISPLAY + mx + 1), 8'h01, 1);
		capture_frame("wb frame");
	endtask

	task automatic test_cursor_moves();
		repeat (20) press(KEY_LEFT);
		repeat (15) press(KEY_UP);
		check_pos("top left", hpos_t'(mx), vpos_t'(my), cursor_x, cursor_y);
		capture_frame("top left frame");
		repeat (40) press(KEY_RIGHT);
		repeat (30) press(KEY_DOWN);
		check_pos("bottom right", hpos_t'(mx), vpos_t'(my), cursor_x, cursor_y);
		capture_frame("bottom right frame");
	endtask

	task automatic test_paint_erase();
		repeat (10) press(KEY_LEFT);
		repeat (10) press(KEY_UP);
		check_pos("paint", hpos_t'(mx), vpos_t'(my), cursor_x, cursor_y);
		press(KEY_PAINT);
		wb_read_check("paint read", wb_adr_t'(my * `H_DISPLAY + mx));
		// step clear of the box so the red pixel shows
		repeat (4) press(KEY_RIGHT);
		capture_frame("paint frame");
		repeat (4) press(KEY_LEFT);
		press(KEY_ERASE);
		wb_read_check("erase read", wb_adr_t'(my * `H_DISPLAY + mx));
	endtask

	task automatic test_paint_with_bus();
		wb_adr_t paint_a;
		wb_adr_t paint_b;
		paint_a = wb_adr_t'(my * `H_DISPLAY + mx);
		// tick and request start together so the bus write goes first
		fork
			press(KEY_PAINT);
			wb_write("bus with paint", 10'd0, 8'h01, 1);
		join
		press(KEY_RIGHT);
		paint_b = wb_adr_t'(my * `H_DISPLAY + mx);
		// paint request meets the bus write and delays the ack by one cycle
		fork
			press(KEY_PAINT);
			begin
				step();
				wb_write("bus after paint", 10'd767, 8'h01, 2);
			end
		join
		wb_read_check("painted a", paint_a);
		wb_read_check("painted b", paint_b);
		wb_read_check("bus pixel 0", 10'd0);
		wb_read_check("bus pixel 767", 10'd767);
	endtask

	initial begin
		#(TIMEOUT_NS);
		fail_now("watchdog expired, the run took too long");
	end

	initial begin
		reset = 1'b1;
		key = KEY_NONE;
		move_tick = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		mx = `H_DISPLAY / 2;
		my = `V_DISPLAY / 2;
		test_reset();
		test_wb_random();
		test_wb_frame();
		test_cursor_moves();
		test_paint_erase();
		test_paint_with_bus();
		$display("All tests passed");
		$finish;
	end

endmodule

// File: sim.f
+incdir+.
vga_scan_pkg.sv
paint_pkg.sv
scan_if.sv
cursor_if.sv
scan_timing.sv
cursor_ctrl.sv
frame_buffer.sv
sprite_overlay.sv
paint_top.sv
tb_paint_top.sv

// File: Bender.yml
package:
  name: paint_subsystem

sources:
  - include_dirs:
      - .
    files:
      - vga_scan_pkg.sv
      - paint_pkg.sv
      - scan_if.sv
      - cursor_if.sv
      - scan_timing.sv
      - cursor_ctrl.sv
      - frame_buffer.sv
      - sprite_overlay.sv
      - paint_top.sv
      - target: simulation
        files:
          - tb_paint_top.sv
